//--- Makefile
SIM  := obj_dir/Vtb_audio_fx
SRCS := $(filter-out +%,$(shell cat verilog.f)) rtl/audio_fx_cfg.svh

.PHONY: run clean

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f verilog.f --top-module tb_audio_fx -Mdir obj_dir

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Verification passed$$'

clean:
	rm -rf obj_dir

//--- dv/audio_fx_properties.sv
// -------------------------------------------------------------------------
// Concurrent assertions on the effects core ports, bound to the top level
// -------------------------------------------------------------------------
module audio_fx_properties (
  input logic               es1_dlrc,
  input logic               sys_rst,
  input logic               i_sample_valid,
  input logic               o_sample_valid,
  input audio_pkg::sample_t o_sample,
  input logic               o_voice_flag
);
  timeunit 1ns;
  timeprecision 100ps;

  // two-stage pipeline, no stalls
  valid_latency_a: assert property (@(posedge es1_dlrc) disable iff (!sys_rst)
    i_sample_valid |-> ##2 o_sample_valid)
    else $error("output strobe missing two cycles after an input strobe");

  valid_origin_a: assert property (@(posedge es1_dlrc) disable iff (!sys_rst)
    o_sample_valid |-> $past(i_sample_valid, 2))
    else $error("output strobe without an input strobe two cycles earlier");

  reset_quiet_a: assert property (@(posedge es1_dlrc)
    !sys_rst |-> (!o_sample_valid && !o_voice_flag))
    else $error("outputs not low during reset");

  known_out_a: assert property (@(posedge es1_dlrc) disable iff (!sys_rst)
    o_sample_valid |-> (!$isunknown(o_sample) && !$isunknown(o_voice_flag)))
    else $error("unknown value on the outputs while valid");

endmodule

bind audio_fx_top audio_fx_properties u_properties (
  .es1_dlrc       (es1_dlrc),
  .sys_rst        (sys_rst),
  .i_sample_valid (i_sample_valid),
  .o_sample_valid (o_sample_valid),
  .o_sample       (o_sample),
  .o_voice_flag   (o_voice_flag)
);

//--- dv/tb_audio_fx.sv
// -------------------------------------------------------------------------
// Testbench for the effects core: LFSR stimulus, reference model,
// compare tasks, watchdog and report
// -------------------------------------------------------------------------
`include "audio_fx_cfg.svh"

module tb_audio_fx;
  timeunit 1ns;
  timeprecision 100ps;
  import audio_pkg::*;
  import cmd_pkg::*;

  localparam int DELAY      = `AFX_ECHO_DELAY;
  localparam int N_PASS     = 24;
  localparam int N_ECHO     = 32;
  localparam int N_VOICE    = 11;  // per mode segment, odd to cross phases
  localparam int N_GATE_LVL = 8;
  localparam int N_GATE_SMP = 6;
  localparam int N_TIMING   = 24;
  localparam int TOTAL_STROBES = N_PASS + 2 + 1 + N_ECHO + 3 * (N_VOICE + 1)
                               + N_GATE_LVL * (N_GATE_SMP + 1) + N_TIMING;

  logic      es1_dlrc;
  logic      sys_rst;
  logic      i_cmd_valid;
  cmd_byte_t i_cmd_data;
  logic      i_sample_valid;
  sample_t   i_sample;
  logic      o_sample_valid;
  sample_t   o_sample;
  logic      o_voice_flag;

  logic [15:0]  lfsr_q = 16'd74;
  sample_t      exp_sample_q[$];
  logic         exp_flag_q[$];
  string        cur_test;
  int           n_checks, n_errors, n_tests, test_errors;
  route_t       m_route;  // model state
  change_mode_t m_mode;
  gate_level_t  m_level;
  logic         m_phase;
  sample_t      m_hold;
  sample_t      m_hist [DELAY];

  audio_fx_top UUT (.*);

  initial begin
    es1_dlrc = 1'b0;
    forever #4 es1_dlrc = ~es1_dlrc;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  // full scale down to small values by a random shift
  function automatic sample_t rand_sample();
    sample_t raw;
    logic [1:0] shamt;
    raw = sample_t'(16'(take_bits(16)));
    shamt = 2'(take_bits(2));
    return raw >>> (2 * shamt);
  endfunction

  function automatic mag_t abs_mag(input sample_t s);
    return (s == -32768) ? mag_t'(32767) : ((s < 0) ? mag_t'(-s) : mag_t'(s));
  endfunction

  function automatic sample_t clip_sample(input int v);
    return (v > 32767) ? sample_t'(32767) : ((v < -32768) ? sample_t'(-32768) : sample_t'(v));
  endfunction

  task automatic reset_model();
    m_route = ROUTE_DRY;
    m_mode  = CHANGE_OCTAVE;
    m_level = 4'd1;
    m_phase = 1'b0;
    for (int i = 0; i < DELAY; i++) begin
      m_hist[i] = '0;
    end
  endtask

  // expected output under the held settings, then advance effect state
  task automatic predict_sample(input sample_t s);
    sample_t out_v;
    case (m_route)
      ROUTE_ECHO:   out_v = clip_sample(int'(s) - (int'(m_hist[DELAY-1]) >>> 1));
      ROUTE_CHANGE: out_v = !m_phase ? s : ((m_mode == CHANGE_RING) ? clip_sample(-int'(s))
                                                                     : m_hold);
      ROUTE_GATE:   out_v = (int'(abs_mag(s)) < int'(m_level) * `AFX_GATE_STEP) ? '0 : s;
      default:      out_v = s;
    endcase
    exp_sample_q.push_back(out_v);
    exp_flag_q.push_back(abs_mag(s) > mag_t'(`AFX_VOICE_THRESH));
    if (!m_phase) begin
      m_hold = s;
    end
    m_phase = ~m_phase;
    for (int i = DELAY - 1; i > 0; i--) begin
      m_hist[i] = m_hist[i-1];
    end
    m_hist[0] = s;
  endtask

  task automatic apply_cmd(input cmd_byte_t c);
    case (c[7:4])
      4'd1: m_route = ROUTE_ECHO;
      4'd2: begin
        m_route = ROUTE_CHANGE;
        m_mode  = c[0] ? CHANGE_RING : CHANGE_OCTAVE;
      end
      4'd3: begin
        m_route = ROUTE_GATE;
        m_level = c[3:0];
      end
      default: m_route = ROUTE_DRY;
    endcase
  endtask

  task automatic check_sample(input string name, input sample_t exp_v, input sample_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      $display("** Error %s: sample expected %0d, actual %0d", name, exp_v, act_v);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      $display("** Error %s: flag expected %0b, actual %0b", name, exp_v, act_v);
      n_errors++;
      test_errors++;
    end
  endtask

  // one cycle of input, driven after the edge
  task automatic step(input logic sv, input sample_t s, input logic cv, input cmd_byte_t c);
    @(posedge es1_dlrc);
    #1;
    i_sample_valid = sv;
    i_sample       = s;
    i_cmd_valid    = cv;
    i_cmd_data     = c;
    if (sv) begin
      predict_sample(s);  // old settings win on a shared edge
    end
    if (cv) begin
      apply_cmd(c);
    end
  endtask

  task automatic send_sample(input sample_t s);
    step(1'b1, s, 1'b0, '0);
    step(1'b0, '0, 1'b0, '0);
  endtask

  task automatic send_cmd(input cmd_byte_t c);
    step(1'b0, '0, 1'b1, c);
    step(1'b0, '0, 1'b0, '0);
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic report_test();
    while (exp_sample_q.size() != 0) begin
      @(posedge es1_dlrc);
    end
    n_tests++;
    $display("test %-12s %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "FAILED",
             test_errors);
  endtask

  // outputs are stable at the falling edge
  always @(negedge es1_dlrc) begin
    if (sys_rst && o_sample_valid) begin
      if (exp_sample_q.size() == 0) begin
        $display("%s: an output sample came out with none pending", cur_test);
        n_errors++;
        test_errors++;
      end else begin
        check_sample(cur_test, exp_sample_q.pop_front(), o_sample);
        check_flag(cur_test, exp_flag_q.pop_front(), o_voice_flag);
      end
    end
  end

  initial begin
    repeat (TOTAL_STROBES * 4 + 100) @(posedge es1_dlrc);
    $display("timeout: the tests did not finish in time");
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic cv;
    i_cmd_valid    = 1'b0;
    i_cmd_data     = '0;
    i_sample_valid = 1'b0;
    i_sample       = '0;
    sys_rst        = 1'b0;
    reset_model();
    begin_test("passthrough");
    repeat (4) @(posedge es1_dlrc);
    #1;
    check_flag("reset", 1'b0, o_sample_valid);
    check_flag("reset", 1'b0, o_voice_flag);
    sys_rst = 1'b1;
    send_sample(sample_t'(-32768));  // magnitude clips at full scale
    send_sample(sample_t'(32767));
    repeat (N_PASS) send_sample(rand_sample());
    report_test();

    begin_test("echo");
    send_cmd({4'h1, 4'(take_bits(4))});
    repeat (N_ECHO) send_sample(rand_sample());
    report_test();

    begin_test("voice_change");
    send_cmd({4'h2, 3'(take_bits(3)), 1'b0});
    repeat (N_VOICE) send_sample(rand_sample());
    send_cmd({4'h2, 3'(take_bits(3)), 1'b1});
    repeat (N_VOICE) send_sample(rand_sample());
    send_cmd({4'h2, 3'(take_bits(3)), 1'b0});
    repeat (N_VOICE) send_sample(rand_sample());
    report_test();

    begin_test("noise_gate");
    repeat (N_GATE_LVL) begin
      send_cmd({4'h3, 4'(take_bits(4))});
      repeat (N_GATE_SMP) send_sample(rand_sample());
    end
    report_test();

    // back-to-back samples with random commands on the same edge
    begin_test("cmd_timing");
    repeat (N_TIMING) begin
      cv = 1'(take_bits(1));
      step(1'b1, rand_sample(), cv, 8'(take_bits(8)));
    end
    step(1'b0, '0, 1'b0, '0);
    report_test();

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- rtl/audio_fx_cfg.svh
// -------------------------------------------------------------------------
// Widths and constants of the audio effects core
// -------------------------------------------------------------------------
`ifndef AUDIO_FX_CFG_SVH
`define AUDIO_FX_CFG_SVH

// pcm sample width, left channel only
`define AFX_SAMPLE_W 16

// echo tap distance in samples
`define AFX_ECHO_DELAY 8

// magnitude added per gate level step
`define AFX_GATE_STEP 256

// magnitude above which the voice led lights
`define AFX_VOICE_THRESH 2048

`endif

//--- rtl/audio_fx_top.sv
// -------------------------------------------------------------------------
// Audio command and effects core on the DAC frame clock
// -------------------------------------------------------------------------
module audio_fx_top (
  input  logic               es1_dlrc,
  input  logic               sys_rst,
  input  logic               i_cmd_valid,
  input  cmd_pkg::cmd_byte_t i_cmd_data,
  input  logic               i_sample_valid,
  input  audio_pkg::sample_t i_sample,
  output logic               o_sample_valid,
  output audio_pkg::sample_t o_sample,
  output logic               o_voice_flag
);
  import audio_pkg::*;
  import cmd_pkg::*;

  change_mode_t change_mode;
  gate_level_t  gate_level;

  fx_bus_if u_bus ();

  cmd_decoder u_cmd_decoder (
    .es1_dlrc       (es1_dlrc),
    .sys_rst        (sys_rst),
    .i_cmd_valid    (i_cmd_valid),
    .i_cmd_data     (i_cmd_data),
    .i_sample_valid (i_sample_valid),
    .i_sample       (i_sample),
    .o_change_mode  (change_mode),
    .o_gate_level   (gate_level),
    .bus            (u_bus.ctrl)
  );

  echo_canceller u_echo_canceller (
    .es1_dlrc       (es1_dlrc),
    .sys_rst        (sys_rst),
    .i_sample_valid (i_sample_valid),
    .i_sample       (i_sample),
    .bus            (u_bus.echo)
  );

  voice_changer u_voice_changer (
    .es1_dlrc       (es1_dlrc),
    .sys_rst        (sys_rst),
    .i_sample_valid (i_sample_valid),
    .i_sample       (i_sample),
    .i_change_mode  (change_mode),
    .bus            (u_bus.change)
  );

  noise_gate u_noise_gate (
    .es1_dlrc       (es1_dlrc),
    .sys_rst        (sys_rst),
    .i_sample_valid (i_sample_valid),
    .i_sample       (i_sample),
    .i_gate_level   (gate_level),
    .bus            (u_bus.gate)
  );

  output_select u_output_select (
    .es1_dlrc       (es1_dlrc),
    .sys_rst        (sys_rst),
    .bus            (u_bus.sink),
    .o_sample_valid (o_sample_valid),
    .o_sample       (o_sample),
    .o_voice_flag   (o_voice_flag)
  );

endmodule

//--- rtl/audio_pkg.sv
// -------------------------------------------------------------------------
// Sample, magnitude and gate level types with the magnitude helper
// -------------------------------------------------------------------------
`include "audio_fx_cfg.svh"

package audio_pkg;

  typedef logic signed [`AFX_SAMPLE_W-1:0] sample_t;  // two's complement pcm
  typedef logic [`AFX_SAMPLE_W-1:0]        mag_t;
  typedef logic [3:0]                      gate_level_t;  // command low nibble

  localparam sample_t SAMPLE_MAX = {1'b0, {(`AFX_SAMPLE_W-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(`AFX_SAMPLE_W-1){1'b0}}};

  // absolute value, most negative sample clips to full scale
  function automatic mag_t mag_of(input sample_t s);
    mag_t m;
    if (s == SAMPLE_MIN) begin
      m = mag_t'(SAMPLE_MAX);
    end else if (s < 0) begin
      m = mag_t'(-s);
    end else begin
      m = mag_t'(s);
    end
    return m;
  endfunction

endpackage

//--- rtl/cmd_decoder.sv
// -------------------------------------------------------------------------
// Command byte decoder holding route, change mode and gate level,
// and the stage-1 launch of each dry sample
// -------------------------------------------------------------------------
module cmd_decoder (
  input  logic                   es1_dlrc,
  input  logic                   sys_rst,
  input  logic                   i_cmd_valid,
  input  cmd_pkg::cmd_byte_t     i_cmd_data,
  input  logic                   i_sample_valid,
  input  audio_pkg::sample_t     i_sample,
  output cmd_pkg::change_mode_t  o_change_mode,
  output audio_pkg::gate_level_t o_gate_level,
  fx_bus_if.ctrl                 bus
);
  import audio_pkg::*;
  import cmd_pkg::*;

  opcode_t opcode;
  route_t  route_q;

  assign opcode = i_cmd_data[7:4];

  // arbitration on the upper nibble, one byte per strobe
  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      route_q       <= ROUTE_DRY;
      o_change_mode <= CHANGE_OCTAVE;
      o_gate_level  <= gate_level_t'(1);
    end else if (i_cmd_valid) begin
      case (opcode)
        OP_ECHO: begin
          route_q <= ROUTE_ECHO;
        end
        OP_CHANGE: begin
          route_q       <= ROUTE_CHANGE;
          o_change_mode <= change_mode_t'(i_cmd_data[0]);  // bit 0 picks the mode
        end
        OP_GATE: begin
          route_q      <= ROUTE_GATE;
          o_gate_level <= gate_level_t'(i_cmd_data[3:0]);
        end
        default: begin
          route_q <= ROUTE_DRY;  // separation and unknown codes pass through
        end
      endcase
    end
  end

  // stage 1 strobe and route, old route wins over a same-edge command
  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      bus.valid <= 1'b0;
      bus.route <= ROUTE_DRY;
    end else begin
      bus.valid <= i_sample_valid;
      if (i_sample_valid) begin
        bus.route <= route_q;
      end
    end
  end

  always_ff @(posedge es1_dlrc) begin
    if (i_sample_valid) begin
      bus.dry <= i_sample;  // also feeds the level detector
    end
  end

endmodule

//--- rtl/cmd_pkg.sv
// -------------------------------------------------------------------------
// Command byte, opcode, output route and voice change mode types
// -------------------------------------------------------------------------
package cmd_pkg;

  typedef logic [7:0] cmd_byte_t;
  typedef logic [3:0] opcode_t;  // upper nibble of the command byte

  // stage-1 result picked by the output selector
  typedef enum logic [1:0] {
    ROUTE_DRY,
    ROUTE_ECHO,
    ROUTE_CHANGE,
    ROUTE_GATE
  } route_t;

  typedef enum logic {
    CHANGE_OCTAVE,  // sample-hold, one octave down
    CHANGE_RING     // alternating sign
  } change_mode_t;

  // opcodes still in use; separation and the rest fall back to dry
  localparam opcode_t OP_ECHO   = 4'd1;
  localparam opcode_t OP_CHANGE = 4'd2;
  localparam opcode_t OP_GATE   = 4'd3;

endpackage

//--- rtl/echo_canceller.sv
// -------------------------------------------------------------------------
// Echo canceller: sample delay line and saturating subtraction
// of half the delayed sample
// -------------------------------------------------------------------------
`include "audio_fx_cfg.svh"

module echo_canceller (
  input  logic               es1_dlrc,
  input  logic               sys_rst,
  input  logic               i_sample_valid,
  input  audio_pkg::sample_t i_sample,
  fx_bus_if.echo             bus
);
  import audio_pkg::*;

  localparam int DELAY = `AFX_ECHO_DELAY;

  sample_t                       history [DELAY];  // [0] is the previous sample
  sample_t                       tap_half;
  logic signed [`AFX_SAMPLE_W:0] diff;             // one guard bit
  sample_t                       diff_sat;

  assign tap_half = history[DELAY-1] >>> 1;
  assign diff     = i_sample - tap_half;

  // clip when the guard bit disagrees with the sign
  always_comb begin
    if (diff[`AFX_SAMPLE_W] != diff[`AFX_SAMPLE_W-1]) begin
      diff_sat = diff[`AFX_SAMPLE_W] ? SAMPLE_MIN : SAMPLE_MAX;
    end else begin
      diff_sat = sample_t'(diff);
    end
  end

  // history runs on every strobe, whatever the route
  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      for (int i = 0; i < DELAY; i++) begin
        history[i] <= '0;
      end
    end else if (i_sample_valid) begin
      history[0] <= i_sample;
      for (int i = 1; i < DELAY; i++) begin
        history[i] <= history[i-1];
      end
    end
  end

  always_ff @(posedge es1_dlrc) begin
    if (i_sample_valid) begin
      bus.echoed <= diff_sat;
    end
  end

endmodule

//--- rtl/fx_bus_if.sv
// -------------------------------------------------------------------------
// Stage-1 bus from the effect blocks to the output selector
// -------------------------------------------------------------------------
interface fx_bus_if;
  import audio_pkg::*;
  import cmd_pkg::*;

  logic    valid;    // stage-1 sample strobe
  route_t  route;    // route held when the sample arrived
  sample_t dry;      // unprocessed sample
  sample_t echoed;   // echo cancelled
  sample_t changed;  // voice changed
  sample_t gated;    // noise gated

  modport ctrl (output valid, output route, output dry);
  modport echo (output echoed);
  modport change (output changed);
  modport gate (output gated);

  modport sink (
    input valid,
    input route,
    input dry,
    input echoed,
    input changed,
    input gated
  );

endinterface

//--- rtl/noise_gate.sv
// -------------------------------------------------------------------------
// Noise gate with a threshold set by the command level
// -------------------------------------------------------------------------
`include "audio_fx_cfg.svh"

module noise_gate (
  input  logic                   es1_dlrc,
  input  logic                   sys_rst,
  input  logic                   i_sample_valid,
  input  audio_pkg::sample_t     i_sample,
  input  audio_pkg::gate_level_t i_gate_level,
  fx_bus_if.gate                 bus
);
  import audio_pkg::*;

  mag_t mag;
  mag_t thresh;

  assign mag    = mag_of(i_sample);
  assign thresh = mag_t'(i_gate_level) * mag_t'(`AFX_GATE_STEP);  // level 0 opens fully

  // gate output stays silent until the first sample
  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      bus.gated <= '0;
    end else if (i_sample_valid) begin
      if (mag < thresh) begin
        bus.gated <= '0;  // below floor
      end else begin
        bus.gated <= i_sample;
      end
    end
  end

endmodule

//--- rtl/output_select.sv
// -------------------------------------------------------------------------
// Output source multiplexer and input level detector
// -------------------------------------------------------------------------
`include "audio_fx_cfg.svh"

module output_select (
  input  logic               es1_dlrc,
  input  logic               sys_rst,
  fx_bus_if.sink             bus,
  output logic               o_sample_valid,
  output audio_pkg::sample_t o_sample,
  output logic               o_voice_flag
);
  import audio_pkg::*;
  import cmd_pkg::*;

  sample_t sel;
  logic    loud;

  always_comb begin
    case (bus.route)
      ROUTE_ECHO:   sel = bus.echoed;
      ROUTE_CHANGE: sel = bus.changed;
      ROUTE_GATE:   sel = bus.gated;
      default:      sel = bus.dry;
    endcase
  end

  // level taken on the dry sample, not the processed one
  assign loud = mag_of(bus.dry) > mag_t'(`AFX_VOICE_THRESH);

  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      o_sample_valid <= 1'b0;
      o_voice_flag   <= 1'b0;
    end else begin
      o_sample_valid <= bus.valid;
      if (bus.valid) begin
        o_voice_flag <= loud;  // moves with the output strobe
      end
    end
  end

  always_ff @(posedge es1_dlrc) begin
    if (bus.valid) begin
      o_sample <= sel;
    end
  end

endmodule

//--- rtl/voice_changer.sv
// -------------------------------------------------------------------------
// Voice changer: octave-down by sample hold, or ring modulation
// by alternating sign
// -------------------------------------------------------------------------
module voice_changer (
  input  logic                  es1_dlrc,
  input  logic                  sys_rst,
  input  logic                  i_sample_valid,
  input  audio_pkg::sample_t    i_sample,
  input  cmd_pkg::change_mode_t i_change_mode,
  fx_bus_if.change              bus
);
  import audio_pkg::*;
  import cmd_pkg::*;

  logic    phase;    // shared by both modes
  sample_t hold_q;
  sample_t neg_sat;
  sample_t fx_out;

  assign neg_sat = (i_sample == SAMPLE_MIN) ? SAMPLE_MAX : -i_sample;

  always_comb begin
    if (!phase) begin
      fx_out = i_sample;
    end else if (i_change_mode == CHANGE_RING) begin
      fx_out = neg_sat;
    end else begin
      fx_out = hold_q;  // repeat the even sample
    end
  end

  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      phase <= 1'b0;
    end else if (i_sample_valid) begin
      phase <= ~phase;
    end
  end

  always_ff @(posedge es1_dlrc) begin
    if (i_sample_valid) begin
      if (!phase) begin
        hold_q <= i_sample;  // captured in either mode
      end
      bus.changed <= fx_out;
    end
  end

endmodule

//--- verilog.f
+incdir+rtl
rtl/audio_pkg.sv
rtl/cmd_pkg.sv
rtl/fx_bus_if.sv
rtl/cmd_decoder.sv
rtl/echo_canceller.sv
rtl/voice_changer.sv
rtl/noise_gate.sv
rtl/output_select.sv
rtl/audio_fx_top.sv
dv/audio_fx_properties.sv
dv/tb_audio_fx.sv
